// File: agen_defs.svh
`ifndef AGEN_DEFS_SVH
`define AGEN_DEFS_SVH

// linear address and operand width
`define AGEN_AW 32

// selector data width, base is selector << 16
`define AGEN_SELW 16

// segment registers es, cs, ss, ds, fs, gs and two spares
`define AGEN_NSEG 8

// memory access size codes
`define SIZE_B 2'd0
`define SIZE_W 2'd1
`define SIZE_D 2'd2

`endif

// File: agen_pkg.sv
`include "agen_defs.svh"

package agen_pkg;

   typedef logic [`AGEN_AW-1:0] word_t;
   typedef logic [`AGEN_SELW-1:0] sel_t;
   typedef logic [$clog2(`AGEN_NSEG)-1:0] seg_id_t;

   // read address source
   typedef enum logic [1:0] {
      rd_seg1,
      rd_stack,
      rd_intr,
      rd_cmps
   } rd_sel_e;

   // write address source
   typedef enum logic {
      wr_seg1,
      wr_stack
   } wr_sel_e;

   // control-store bits used by this stage
   typedef struct packed {
      logic    mux_imm1;
      rd_sel_e rd_sel;
      wr_sel_e wr_sel;
      logic    repne_steady;
      logic    cmps_first;
      logic    cmps_second;
      logic    jmp_stall;
      logic    near_ret;
      logic    far_ret;
      logic    ld_flags;
      logic    df_affected;
   } agen_ctrl_t;

   // fields carried untouched to execute
   typedef struct packed {
      word_t       neip;
      sel_t        ncs;
      logic [2:0]  drid1;
      logic [2:0]  drid2;
      logic [2:0]  aluk;
      logic        ld_gpr1;
      logic        ld_mm;
      logic [1:0]  dr1_size;
      logic [1:0]  dr2_size;
      logic [63:0] mm_a;
      logic [63:0] mm_b;
   } agen_pass_t;

   // stage-1 bundle
   typedef struct packed {
      logic       v;
      word_t      eip;
      word_t      a;
      word_t      b;
      word_t      sp_xchg;
      word_t      base_disp;
      word_t      sib_seg1;
      word_t      sib_si;
      sel_t       seg1_data;
      sel_t       seg2_data;
      word_t      intr_addr;
      seg_id_t    seg1_id;
      logic       mem_rd;
      logic       mem_wr;
      logic [1:0] mem_size;
      logic       repne;
      logic       df;
      logic       page_fault;
      agen_ctrl_t ctrl;
      agen_pass_t pass;
   } agen_in_t;

   // bundle toward execute
   typedef struct packed {
      logic       v;
      word_t      a;
      word_t      b;
      word_t      sp_xchg;
      word_t      mem_rd_addr;
      word_t      mem_wr_addr;
      logic       mem_rd;
      logic       mem_wr;
      logic [1:0] mem_size;
      logic       seg_exc;
      logic       page_fault;
      logic       repne;
      logic       jmp_stall;
      logic       v_ld_df;
      agen_pass_t pass;
   } agen_out_t;

   // segment limit table write
   typedef struct packed {
      logic    en;
      seg_id_t id;
      word_t   limit;
   } seg_wr_t;

   // current cmps pointer and its saved segment
   typedef struct packed {
      word_t   ptr;
      seg_id_t seg;
   } cmps_ptr_t;

   // combinational results of the address stage
   typedef struct packed {
      word_t   a;
      word_t   b;
      word_t   rd_addr;
      word_t   wr_addr;
      word_t   chk_base;
      seg_id_t chk_seg;
   } agen_calc_t;

   // access size in bytes
   function automatic word_t size_bytes(input logic [1:0] size);
      case (size)
         `SIZE_B: return word_t'(1);
         `SIZE_W: return word_t'(2);
         default: return word_t'(4);
      endcase
   endfunction

endpackage

// File: agen_in_latch.sv
`timescale 1ns/1ns

module agen_in_latch (
   input  logic              clk,
   input  logic              rst,
   input  agen_pkg::agen_in_t stage_in,
   input  agen_pkg::seg_wr_t  seg_wr,
   output agen_pkg::agen_in_t lat,
   output agen_pkg::seg_wr_t  lat_seg_wr
);

   // payload loads every cycle, only the valid and strobes reset
   always_ff @(posedge clk) begin
      lat        <= stage_in;
      lat_seg_wr <= seg_wr;
      if (rst) begin
         lat.v         <= 1'b0;
         lat.mem_rd    <= 1'b0;
         lat.mem_wr    <= 1'b0;
         lat_seg_wr.en <= 1'b0;
      end
   end

   // the cmps read source is only legal inside a string op
   // decode must never hand one over outside repne or a cmps uop
   a_cmps_src_legal : assert property (
      @(posedge clk) disable iff (rst)
      (lat.v && lat.ctrl.rd_sel == agen_pkg::rd_cmps) |->
         (lat.repne || lat.ctrl.cmps_first || lat.ctrl.cmps_second)
   ) else $error("cmps read source without repne or cmps uop");

endmodule

// File: agen_addr_calc.sv
`timescale 1ns/1ns

`include "agen_defs.svh"

module agen_addr_calc (
   input  agen_pkg::agen_in_t   lat,
   input  agen_pkg::cmps_ptr_t  cmps,
   output agen_pkg::agen_calc_t calc_out
);

   agen_pkg::word_t seg1_base;
   agen_pkg::word_t seg2_base;
   agen_pkg::word_t seg1_addr;
   agen_pkg::word_t stack_addr;
   agen_pkg::word_t repne_base;
   agen_pkg::word_t cmps_addr;
   logic            steady;

   // segment base is the selector data moved to the upper half
   assign seg1_base = {lat.seg1_data, {`AGEN_SELW{1'b0}}};
   assign seg2_base = {lat.seg2_data, {`AGEN_SELW{1'b0}}};

   // base+disp already carries the index, add seg1 base
   assign seg1_addr  = lat.base_disp + lat.sib_seg1;
   assign stack_addr = seg2_base + lat.sp_xchg;

   // after the first iteration the saved pointer replaces A
   assign steady     = lat.ctrl.repne_steady;
   assign repne_base = steady ? cmps.ptr : lat.a;
   assign cmps_addr  = seg1_base + repne_base;

   always_comb begin
      calc_out = '0;

      calc_out.a = lat.repne ? repne_base : lat.a;
      calc_out.b = lat.ctrl.mux_imm1 ? agen_pkg::word_t'(1) : lat.b;

      case (lat.ctrl.rd_sel)
         agen_pkg::rd_seg1:  calc_out.rd_addr = seg1_addr;
         agen_pkg::rd_stack: calc_out.rd_addr = stack_addr;
         agen_pkg::rd_intr:  calc_out.rd_addr = lat.intr_addr;
         default:            calc_out.rd_addr = cmps_addr;
      endcase

      if (lat.ctrl.wr_sel == agen_pkg::wr_stack) begin
         calc_out.wr_addr = stack_addr;
      end else begin
         calc_out.wr_addr = seg1_addr;
      end

      // limit check follows the same pointer and segment as the access
      calc_out.chk_base = repne_base;
      calc_out.chk_seg  = steady ? cmps.seg : lat.seg1_id;
   end

endmodule

// File: cmps_ptr_track.sv
`timescale 1ns/1ns

module cmps_ptr_track (
   input  logic                clk,
   input  logic                rst,
   input  agen_pkg::agen_in_t  lat,
   output agen_pkg::cmps_ptr_t cmps
);

   agen_pkg::word_t   esi_q;
   agen_pkg::word_t   edi_q;
   agen_pkg::seg_id_t src_seg_q;
   agen_pkg::seg_id_t dst_seg_q;
   agen_pkg::word_t   bytes;
   agen_pkg::word_t   stride;
   agen_pkg::word_t   esi_d;
   agen_pkg::word_t   edi_d;
   logic              ld_esi;
   logic              ld_edi;

   // +size when df is clear, -size when set
   assign bytes  = agen_pkg::size_bytes(lat.mem_size);
   assign stride = lat.df ? -bytes : bytes;

   // steady state walks the saved pointer, otherwise restart from A
   assign esi_d = (lat.ctrl.repne_steady ? esi_q : lat.a) + stride;
   assign edi_d = (lat.ctrl.repne_steady ? edi_q : lat.a) + stride;

   assign ld_esi = lat.v && lat.ctrl.cmps_first;
   assign ld_edi = lat.v && lat.ctrl.cmps_second;

   always_ff @(posedge clk) begin
      if (rst) begin
         esi_q     <= '0;
         edi_q     <= '0;
         src_seg_q <= '0;
         dst_seg_q <= '0;
      end else begin
         if (ld_esi) begin
            esi_q <= esi_d;
            // segment is captured once per string op
            if (!lat.ctrl.repne_steady) begin
               src_seg_q <= lat.seg1_id;
            end
         end
         if (ld_edi) begin
            edi_q <= edi_d;
            if (!lat.ctrl.repne_steady) begin
               dst_seg_q <= lat.seg1_id;
            end
         end
      end
   end

   // second uop reads the destination string
   always_comb begin
      if (lat.ctrl.cmps_second) begin
         cmps.ptr = edi_q;
         cmps.seg = dst_seg_q;
      end else begin
         cmps.ptr = esi_q;
         cmps.seg = src_seg_q;
      end
   end

   // the two cmps uops are issued in separate cycles by the sequencer
   a_cmps_uop_onehot : assert property (
      @(posedge clk) disable iff (rst)
      lat.v |-> !(lat.ctrl.cmps_first && lat.ctrl.cmps_second)
   ) else $error("cmps first and second uop in the same cycle");

endmodule

// File: seg_limit_check.sv
`timescale 1ns/1ns

`include "agen_defs.svh"

module seg_limit_check (
   input  logic               clk,
   input  logic               rst,
   input  agen_pkg::agen_in_t lat,
   input  agen_pkg::seg_wr_t  lat_seg_wr,
   input  agen_pkg::word_t    check_base,
   input  agen_pkg::seg_id_t  check_seg,
   output logic               seg_exc
);

   agen_pkg::word_t     limits [`AGEN_NSEG];
   agen_pkg::word_t     offset;
   logic [`AGEN_AW:0]   last_byte;
   logic                access;

   // limits open to the full 4G after reset
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `AGEN_NSEG; i++) begin
            limits[i] <= '1;
         end
      end else if (lat_seg_wr.en) begin
         limits[lat_seg_wr.id] <= lat_seg_wr.limit;
      end
   end

   // string ops check the walking pointer instead of base+disp
   assign offset = lat.repne ? check_base : lat.base_disp;

   // one extra bit so a wrap past 4G counts as a violation
   assign last_byte = {1'b0, offset} + {1'b0, agen_pkg::size_bytes(lat.mem_size)} - 1'b1;

   assign access  = lat.v && (lat.mem_rd || lat.mem_wr);
   assign seg_exc = access && (last_byte > {1'b0, limits[check_seg]});

endmodule

// File: agen_out_latch.sv
`timescale 1ns/1ns

module agen_out_latch (
   input  logic                 clk,
   input  logic                 rst,
   input  agen_pkg::agen_in_t   lat,
   input  agen_pkg::agen_calc_t calc_out,
   input  logic                 seg_exc,
   output agen_pkg::agen_out_t  stage_out
);

   agen_pkg::agen_out_t out_d;

   always_comb begin
      out_d.v           = lat.v;
      out_d.a           = calc_out.a;
      out_d.b           = calc_out.b;
      out_d.sp_xchg     = lat.sp_xchg;
      out_d.mem_rd_addr = calc_out.rd_addr;
      out_d.mem_wr_addr = calc_out.wr_addr;
      out_d.mem_rd      = lat.mem_rd;
      out_d.mem_wr      = lat.mem_wr;
      out_d.mem_size    = lat.mem_size;
      out_d.seg_exc     = seg_exc;
      out_d.page_fault  = lat.page_fault;
      out_d.repne       = lat.repne;
      // fetch stalls on jumps and on both return flavours
      out_d.jmp_stall   = lat.v && (lat.ctrl.jmp_stall || lat.ctrl.near_ret ||
                                    lat.ctrl.far_ret);
      // df written back only when flags load and df is touched
      out_d.v_ld_df     = lat.v && lat.ctrl.ld_flags && lat.ctrl.df_affected;
      out_d.pass        = lat.pass;
   end

   always_ff @(posedge clk) begin
      stage_out <= out_d;
      if (rst) begin
         stage_out.v         <= 1'b0;
         stage_out.mem_rd    <= 1'b0;
         stage_out.mem_wr    <= 1'b0;
         stage_out.seg_exc   <= 1'b0;
         stage_out.jmp_stall <= 1'b0;
         stage_out.v_ld_df   <= 1'b0;
      end
   end

endmodule

// File: agen_stage2_top.sv
`timescale 1ns/1ns

module agen_stage2_top (
   input  logic                clk,
   input  logic                rst,
   input  agen_pkg::agen_in_t  stage_in,
   input  agen_pkg::seg_wr_t   seg_wr,
   output agen_pkg::agen_out_t stage_out
);

   agen_pkg::agen_in_t   lat;
   agen_pkg::seg_wr_t    lat_seg_wr;
   agen_pkg::cmps_ptr_t  cmps;
   agen_pkg::agen_calc_t calc_out;
   logic                 seg_exc;

   agen_in_latch u_in_latch (
      .clk        (clk),
      .rst        (rst),
      .stage_in   (stage_in),
      .seg_wr     (seg_wr),
      .lat        (lat),
      .lat_seg_wr (lat_seg_wr)
   );

   cmps_ptr_track u_cmps (
      .clk  (clk),
      .rst  (rst),
      .lat  (lat),
      .cmps (cmps)
   );

   agen_addr_calc u_calc (
      .lat      (lat),
      .cmps     (cmps),
      .calc_out (calc_out)
   );

   seg_limit_check u_limit (
      .clk        (clk),
      .rst        (rst),
      .lat        (lat),
      .lat_seg_wr (lat_seg_wr),
      .check_base (calc_out.chk_base),
      .check_seg  (calc_out.chk_seg),
      .seg_exc    (seg_exc)
   );

   agen_out_latch u_out_latch (
      .clk       (clk),
      .rst       (rst),
      .lat       (lat),
      .calc_out  (calc_out),
      .seg_exc   (seg_exc),
      .stage_out (stage_out)
   );

endmodule

// File: tb_agen_stage2.sv
`timescale 1ns/1ns

`include "agen_defs.svh"

module tb_agen_stage2;

   logic                clk;
   logic                rst;
   agen_pkg::agen_in_t  stage_in;
   agen_pkg::seg_wr_t   seg_wr;
   agen_pkg::agen_out_t stage_out;

   // expected bundles, oldest first
   agen_pkg::agen_out_t exp_q[$];

   // model copy of the cmps registers and the limit table
   agen_pkg::word_t     m_esi;
   agen_pkg::word_t     m_edi;
   agen_pkg::seg_id_t   m_sseg;
   agen_pkg::seg_id_t   m_dseg;
   agen_pkg::word_t     m_lim [`AGEN_NSEG];

   int                  checks;
   int                  errors;
   int                  test_checks;
   int                  test_errors;

   agen_stage2_top dut (
      .clk       (clk),
      .rst       (rst),
      .stage_in  (stage_in),
      .seg_wr    (seg_wr),
      .stage_out (stage_out)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      #200000;
      $display("timeout, the run did not reach its end");
      $display("sim failed");
      $finish;
   end

   function automatic agen_pkg::word_t byte_count(input logic [1:0] size);
      if (size == `SIZE_B) return 32'd1;
      else if (size == `SIZE_W) return 32'd2;
      return 32'd4;
   endfunction

   task automatic model_reset();
      m_esi  = '0;
      m_edi  = '0;
      m_sseg = '0;
      m_dseg = '0;
      for (int i = 0; i < `AGEN_NSEG; i++) begin
         m_lim[i] = '1;
      end
   endtask

   // expected output for one bundle, then the model state moves on
   function automatic agen_pkg::agen_out_t ref_agen(input agen_pkg::agen_in_t x,
                                                    input agen_pkg::seg_wr_t w);
      agen_pkg::agen_out_t e;
      agen_pkg::word_t     nbytes;
      agen_pkg::word_t     stride;
      agen_pkg::word_t     base;
      agen_pkg::word_t     seg1_addr;
      agen_pkg::word_t     stack_addr;
      agen_pkg::word_t     offset;
      agen_pkg::seg_id_t   cseg;
      logic [32:0]         last;
      nbytes     = byte_count(x.mem_size);
      stride     = x.df ? (32'd0 - nbytes) : nbytes;
      base       = x.ctrl.cmps_second ? m_edi : m_esi;
      cseg       = x.ctrl.cmps_second ? m_dseg : m_sseg;
      if (!x.ctrl.repne_steady) begin
         base = x.a;
         cseg = x.seg1_id;
      end
      seg1_addr  = x.base_disp + x.sib_seg1;
      stack_addr = {x.seg2_data, 16'h0000} + x.sp_xchg;
      e          = '0;
      e.v        = x.v;
      e.a        = x.repne ? base : x.a;
      e.b        = x.ctrl.mux_imm1 ? 32'd1 : x.b;
      e.sp_xchg  = x.sp_xchg;
      case (x.ctrl.rd_sel)
         agen_pkg::rd_seg1:  e.mem_rd_addr = seg1_addr;
         agen_pkg::rd_stack: e.mem_rd_addr = stack_addr;
         agen_pkg::rd_intr:  e.mem_rd_addr = x.intr_addr;
         default:            e.mem_rd_addr = {x.seg1_data, 16'h0000} + base;
      endcase
      e.mem_wr_addr = (x.ctrl.wr_sel == agen_pkg::wr_stack) ? stack_addr : seg1_addr;
      e.mem_rd      = x.mem_rd;
      e.mem_wr      = x.mem_wr;
      e.mem_size    = x.mem_size;
      offset        = x.repne ? base : x.base_disp;
      last          = {1'b0, offset} + {1'b0, nbytes} - 33'd1;
      e.seg_exc     = x.v && (x.mem_rd || x.mem_wr) && (last > {1'b0, m_lim[cseg]});
      e.page_fault  = x.page_fault;
      e.repne       = x.repne;
      e.jmp_stall   = x.v && (x.ctrl.jmp_stall || x.ctrl.near_ret || x.ctrl.far_ret);
      e.v_ld_df     = x.v && x.ctrl.ld_flags && x.ctrl.df_affected;
      e.pass        = x.pass;
      if (x.v && x.ctrl.cmps_first) begin
         m_esi = (x.ctrl.repne_steady ? m_esi : x.a) + stride;
         if (!x.ctrl.repne_steady) m_sseg = x.seg1_id;
      end
      if (x.v && x.ctrl.cmps_second) begin
         m_edi = (x.ctrl.repne_steady ? m_edi : x.a) + stride;
         if (!x.ctrl.repne_steady) m_dseg = x.seg1_id;
      end
      if (w.en) m_lim[w.id] = w.limit;
      return e;
   endfunction

   // random non-repne bundle that keeps the decode rules
   function automatic agen_pkg::agen_in_t random_bundle();
      logic [$bits(agen_pkg::agen_in_t)-1:0] r;
      agen_pkg::agen_in_t                    x;
      r = '0;
      for (int i = 0; i <= $bits(r) / 32; i++) begin
         r = {r[$bits(r)-33:0], $urandom};
      end
      x       = agen_pkg::agen_in_t'(r);
      x.repne = 1'b0;
      if (x.ctrl.cmps_first && x.ctrl.cmps_second) x.ctrl.cmps_second = 1'b0;
      if (x.ctrl.rd_sel == agen_pkg::rd_cmps && !x.ctrl.cmps_second) x.ctrl.cmps_first = 1'b1;
      return x;
   endfunction

   task automatic check_word(input string name, input agen_pkg::word_t exp, got);
      checks++;
      assert (exp === got) else begin
         $display("mismatch %s exp %h got %h", name, exp, got);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, got);
      checks++;
      assert (exp === got) else begin
         $display("mismatch %s exp %h got %h", name, exp, got);
         errors++;
      end
   endtask

   task automatic drive(input agen_pkg::agen_in_t x, input agen_pkg::seg_wr_t w);
      @(posedge clk);
      #1;
      stage_in = x;
      seg_wr   = w;
      exp_q.push_back(ref_agen(x, w));
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #1;
      rst      = 1'b1;
      stage_in = '0;
      seg_wr   = '0;
      exp_q.delete();
      model_reset();
      for (int k = 0; k < 2; k++) begin
         @(posedge clk);
         #1;
         if (k == 1) rst = 1'b0;
         #1;
         check_bit("stage_out.v", 1'b0, stage_out.v);
         check_bit("stage_out.mem_rd", 1'b0, stage_out.mem_rd);
         check_bit("stage_out.mem_wr", 1'b0, stage_out.mem_wr);
      end
   endtask

   // push idle bundles until the last real result has been compared
   task automatic finish_test(input int num, input string name);
      agen_pkg::agen_in_t idle;
      agen_pkg::seg_wr_t  no_wr;
      int                 n;
      idle  = '0;
      no_wr = '0;
      repeat (3) drive(idle, no_wr);
      n = 0;
      while (exp_q.size() > 2 && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() > 2) begin
         $display("timeout waiting for the results of test %0d", num);
         errors++;
      end
      $display("test %0d %s: %0d checks, %0d errors", num, name,
               checks - test_checks, errors - test_errors);
      test_checks = checks;
      test_errors = errors;
   endtask

   always @(negedge clk) begin : compare
      agen_pkg::agen_out_t e;
      if (exp_q.size() > 2) begin
         e = exp_q.pop_front();
         check_bit("stage_out.v", e.v, stage_out.v);
         check_word("stage_out.a", e.a, stage_out.a);
         check_word("stage_out.b", e.b, stage_out.b);
         check_word("stage_out.mem_rd_addr", e.mem_rd_addr, stage_out.mem_rd_addr);
         check_word("stage_out.mem_wr_addr", e.mem_wr_addr, stage_out.mem_wr_addr);
         check_bit("stage_out.seg_exc", e.seg_exc, stage_out.seg_exc);
         check_bit("stage_out.jmp_stall", e.jmp_stall, stage_out.jmp_stall);
         check_bit("stage_out.v_ld_df", e.v_ld_df, stage_out.v_ld_df);
         checks++;
         assert (stage_out === e) else begin
            $display("mismatch stage_out exp %h got %h", e, stage_out);
            errors++;
         end
         if (!stage_out.v) begin
            checks++;
            assert (!stage_out.jmp_stall && !stage_out.v_ld_df) else begin
               $display("jmp_stall or v_ld_df raised for an invalid bundle");
               errors++;
            end
         end
      end
   end

   initial begin
      agen_pkg::agen_in_t x;
      agen_pkg::seg_wr_t  w;
      agen_pkg::seg_wr_t  no_wr;
      agen_pkg::word_t    lim [`AGEN_NSEG];
      agen_pkg::word_t    off;
      rst         = 1'b1;
      stage_in    = '0;
      seg_wr      = '0;
      no_wr       = '0;
      checks      = 0;
      errors      = 0;
      test_checks = 0;
      test_errors = 0;
      void'($urandom(32'h38af));
      model_reset();
      apply_reset();

      for (int i = 0; i < 400; i++) begin
         x   = random_bundle();
         x.v = 1'b1;
         drive(x, no_wr);
      end
      finish_test(1, "addresses and passthrough");

      // first, second, then steady iterations for each size and direction
      for (int sz = 0; sz < 3; sz++) begin
         for (int df = 0; df < 2; df++) begin
            x                  = '0;
            x.v                = 1'b1;
            x.repne            = 1'b1;
            x.mem_rd           = 1'b1;
            x.mem_size         = 2'(sz);
            x.df               = 1'(df);
            x.ctrl.rd_sel      = agen_pkg::rd_cmps;
            x.seg1_data        = 16'($urandom);
            x.seg1_id          = 3'($urandom);
            x.a                = $urandom;
            x.ctrl.cmps_first  = 1'b1;
            drive(x, no_wr);
            x.ctrl.cmps_first  = 1'b0;
            x.ctrl.cmps_second = 1'b1;
            x.seg1_id          = 3'($urandom);
            x.a                = $urandom;
            drive(x, no_wr);
            x.ctrl.repne_steady = 1'b1;
            for (int k = 0; k < 4; k++) begin
               x.a                = $urandom;
               x.ctrl.cmps_first  = 1'b1;
               x.ctrl.cmps_second = 1'b0;
               drive(x, no_wr);
               x.ctrl.cmps_first  = 1'b0;
               x.ctrl.cmps_second = 1'b1;
               drive(x, no_wr);
            end
         end
      end
      finish_test(2, "repne cmps stepping");

      for (int id = 0; id < `AGEN_NSEG; id++) begin
         lim[id] = 32'h4000 + (id << 12) + ($urandom & 32'hff);
         w.en    = 1'b1;
         w.id    = 3'(id);
         w.limit = lim[id];
         x       = '0;
         drive(x, w);
      end
      // accesses ending on the limit byte and one byte past it
      for (int id = 0; id < `AGEN_NSEG; id++) begin
         for (int kind = 0; kind < 3; kind++) begin
            for (int past = 0; past < 2; past++) begin
               x          = '0;
               x.v        = 1'b1;
               x.mem_size = 2'($urandom % 3);
               x.seg1_id  = 3'(id);
               off        = lim[id] - byte_count(x.mem_size) + 32'd1 + 32'(past);
               if (kind == 0) begin
                  x.mem_rd    = 1'b1;
                  x.base_disp = off;
               end else if (kind == 1) begin
                  x.mem_wr      = 1'b1;
                  x.base_disp   = off;
                  x.ctrl.wr_sel = past ? agen_pkg::wr_stack : agen_pkg::wr_seg1;
               end else begin
                  x.repne           = 1'b1;
                  x.mem_rd          = 1'b1;
                  x.a               = off;
                  x.ctrl.cmps_first = 1'b1;
                  x.ctrl.rd_sel     = agen_pkg::rd_cmps;
               end
               drive(x, no_wr);
            end
         end
      end
      finish_test(3, "segment limits");

      for (int i = 0; i < 300; i++) begin
         x = random_bundle();
         drive(x, no_wr);
      end
      finish_test(4, "stall and df pulses");

      for (int id = 0; id < `AGEN_NSEG; id++) begin
         w.en    = 1'b1;
         w.id    = 3'(id);
         w.limit = 32'h100;
         drive(random_bundle(), w);
      end
      for (int i = 0; i < 20; i++) begin
         drive(random_bundle(), no_wr);
      end
      apply_reset();
      // limits open again, pointers back at zero
      for (int id = 0; id < `AGEN_NSEG; id++) begin
         x           = '0;
         x.v         = 1'b1;
         x.mem_rd    = 1'b1;
         x.mem_size  = `SIZE_D;
         x.base_disp = 32'hffff_fffc;
         x.seg1_id   = 3'(id);
         drive(x, no_wr);
      end
      x                   = '0;
      x.v                 = 1'b1;
      x.repne             = 1'b1;
      x.mem_rd            = 1'b1;
      x.ctrl.rd_sel       = agen_pkg::rd_cmps;
      x.ctrl.repne_steady = 1'b1;
      x.a                 = $urandom;
      x.ctrl.cmps_first   = 1'b1;
      drive(x, no_wr);
      x.ctrl.cmps_first   = 1'b0;
      x.ctrl.cmps_second  = 1'b1;
      drive(x, no_wr);
      finish_test(5, "reset mid-stream");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: project.f
+incdir+.
agen_pkg.sv
agen_in_latch.sv
agen_addr_calc.sv
cmps_ptr_track.sv
seg_limit_check.sv
agen_out_latch.sv
agen_stage2_top.sv
tb_agen_stage2.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the agen stage 2 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_agen_stage2 \
   -f project.f --Mdir obj_dir -o sim_agen
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_agen > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "sim failed" sim.log; then
   exit 1
fi
exit 0
